/* prefetch_pkg.sv */
// prefetch package
// shared widths, depths, boot address and the fetch entry type
// for the instruction prefetch buffer
`default_nettype none

package prefetch_pkg;

    // bus and instruction widths
    localparam int unsigned ADDR_WIDTH  = 32;
    localparam int unsigned INSTR_WIDTH = 32;

    // first fetch address after reset, word aligned
    localparam logic [ADDR_WIDTH-1:0] BOOT_ADDR = 32'h0000_0080;

    // buffer sizing
    localparam int unsigned FETCH_DEPTH     = 4;
    localparam int unsigned MAX_OUTSTANDING = 2;

    // usage counter widths of the two fifos, 0..DEPTH inclusive
    localparam int unsigned ADDR_CNT_WIDTH  = $clog2(MAX_OUTSTANDING) + 1;
    localparam int unsigned INSTR_CNT_WIDTH = $clog2(FETCH_DEPTH) + 1;

    // one fetched word together with the address it came from
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  addr;
        logic [INSTR_WIDTH-1:0] instr;
    } fetch_entry_t;

endpackage

`default_nettype wire

/* prefetch_fifo.sv */
// prefetch fifo
// circular buffer with a payload type parameter, full/empty/usage flags
// and a synchronous flush; head data is registered, no fall-through
`default_nettype none

module prefetch_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type dtype = logic [31:0]
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // drops every stored entry at the next edge
    input  logic                   flush_i,
    input  logic                   push_i,
    input  logic                   pop_i,
    input  dtype                   data_i,
    output logic                   full_o,
    output logic                   empty_o,
    output logic [$clog2(DEPTH):0] usage_o,
    output dtype                   data_o
);

    // pointer needs at least one bit even for a single entry
    localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_WIDTH = $clog2(DEPTH) + 1;
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(DEPTH - 1);
    localparam logic [CNT_WIDTH-1:0] FULL_CNT = CNT_WIDTH'(DEPTH);

    // storage array
    dtype mem_q [DEPTH];

    // read side, write side and fill level
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_d;
    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] wr_ptr_d;
    logic [CNT_WIDTH-1:0] cnt_q;
    logic [CNT_WIDTH-1:0] cnt_d;

    // requests that actually take effect this cycle
    logic push_ok;
    logic pop_ok;

    // status flags straight from the fill counter
    assign full_o  = (cnt_q == FULL_CNT);
    assign empty_o = (cnt_q == '0);
    assign usage_o = cnt_q;

    // a push into a full buffer or a pop from an empty one is ignored
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    // head of the queue
    assign data_o = mem_q[rd_ptr_q];

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        // write pointer wraps at the last slot
        if (push_ok) begin
            wr_ptr_d = (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
        end

        // same wrap rule for the read side
        if (pop_ok) begin
            rd_ptr_d = (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
        end

        // push and pop together leave the level unchanged
        case ({push_ok, pop_ok})
            2'b10:   cnt_d = cnt_q + 1'b1;
            2'b01:   cnt_d = cnt_q - 1'b1;
            default: cnt_d = cnt_q;
        endcase
    end

    // control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush wins over any push or pop in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // storage is only written on an accepted push
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
// fetch controller
// issues sequential word reads, throttles on buffer space and
// throws away responses that belong to the path before a branch
`default_nettype none

module fetch_ctrl (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   branch_i,
    input  logic [prefetch_pkg::ADDR_WIDTH-1:0]     branch_addr_i,
    output logic                                   instr_req_o,
    output logic [prefetch_pkg::ADDR_WIDTH-1:0]     instr_addr_o,
    input  logic                                   instr_gnt_i,
    input  logic                                   instr_rvalid_i,
    input  logic [prefetch_pkg::INSTR_WIDTH-1:0]    instr_rdata_i,
    input  logic [prefetch_pkg::ADDR_CNT_WIDTH-1:0]  addr_fifo_usage_i,
    input  logic [prefetch_pkg::INSTR_CNT_WIDTH-1:0] instr_fifo_usage_i,
    input  logic [prefetch_pkg::ADDR_WIDTH-1:0]     addr_fifo_data_i,
    output logic                                   addr_fifo_push_o,
    output logic                                   addr_fifo_pop_o,
    output logic                                   instr_fifo_push_o,
    output prefetch_pkg::fetch_entry_t             instr_fifo_data_o
);
    import prefetch_pkg::*;

    // wide enough for in-flight plus stored without overflow
    localparam int unsigned SUM_WIDTH =
        ((ADDR_CNT_WIDTH > INSTR_CNT_WIDTH) ? ADDR_CNT_WIDTH : INSTR_CNT_WIDTH) + 1;

    logic                      active_q;
    logic [ADDR_WIDTH-1:0]     next_addr_q;
    logic                      redirect_q;
    logic [ADDR_WIDTH-1:0]     redirect_addr_q;
    logic [ADDR_CNT_WIDTH-1:0] discard_q;
    logic [ADDR_CNT_WIDTH-1:0] discard_load;
    logic [SUM_WIDTH-1:0]      pending_sum;
    logic                      space_ok;
    logic                      accept;
    logic                      keep;

    // granted-but-unanswered requests plus entries waiting for the core
    assign pending_sum = SUM_WIDTH'(addr_fifo_usage_i) + SUM_WIDTH'(instr_fifo_usage_i);
    assign space_ok    = (pending_sum < SUM_WIDTH'(FETCH_DEPTH)) &&
                         (addr_fifo_usage_i < ADDR_CNT_WIDTH'(MAX_OUTSTANDING));

    // a held request never loses its space: the sum only grows on a grant
    assign instr_req_o  = active_q & space_ok;
    assign instr_addr_o = next_addr_q;
    assign accept       = instr_req_o & instr_gnt_i;

    // address fifo tracks every granted request until its rvalid
    assign addr_fifo_push_o = accept;
    assign addr_fifo_pop_o  = instr_rvalid_i;

    // a response in the branch cycle is always stale
    assign keep              = instr_rvalid_i & (discard_q == '0) & ~branch_i;
    assign instr_fifo_push_o = keep;
    assign instr_fifo_data_o.addr  = addr_fifo_data_i;
    assign instr_fifo_data_o.instr = instr_rdata_i;

    // everything still owed by memory at the branch, including a request
    // on the bus now: granted this cycle or held until granted later
    assign discard_load = addr_fifo_usage_i + ADDR_CNT_WIDTH'(instr_req_o)
                        - ADDR_CNT_WIDTH'(instr_rvalid_i);

    // request generation starts one cycle after reset release
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    // fetch address with branch redirect
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_addr_q <= BOOT_ADDR;
            redirect_q  <= 1'b0;
        end else if (branch_i) begin
            if (instr_req_o && !instr_gnt_i) begin
                // keep the old address on the bus until it is granted
                redirect_q <= 1'b1;
            end else begin
                next_addr_q <= branch_addr_i;
                redirect_q  <= 1'b0;
            end
        end else if (accept) begin
            if (redirect_q) begin
                // held request went out, now switch to the branch target
                next_addr_q <= redirect_addr_q;
                redirect_q  <= 1'b0;
            end else begin
                next_addr_q <= next_addr_q + ADDR_WIDTH'(4);
            end
        end
    end

    // branch target parked while an old request waits for its grant
    always_ff @(posedge clk_i) begin
        if (branch_i) begin
            redirect_addr_q <= branch_addr_i;
        end
    end

    // stale response counter
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            discard_q <= '0;
        end else if (branch_i) begin
            discard_q <= discard_load;
        end else if (instr_rvalid_i && (discard_q != '0)) begin
            discard_q <= discard_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* prefetch_buffer.sv */
// instruction prefetch buffer
// fetch controller plus an address fifo for in-flight requests
// and an instruction fifo holding fetched words for the core
`default_nettype none

module prefetch_buffer (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // core side
    input  logic                                branch_i,
    input  logic [prefetch_pkg::ADDR_WIDTH-1:0]  branch_addr_i,
    input  logic                                fetch_pop_i,
    output logic                                fetch_valid_o,
    output logic [prefetch_pkg::ADDR_WIDTH-1:0]  fetch_addr_o,
    output logic [prefetch_pkg::INSTR_WIDTH-1:0] fetch_instr_o,
    // instruction memory side
    output logic                                instr_req_o,
    output logic [prefetch_pkg::ADDR_WIDTH-1:0]  instr_addr_o,
    input  logic                                instr_gnt_i,
    input  logic                                instr_rvalid_i,
    input  logic [prefetch_pkg::INSTR_WIDTH-1:0] instr_rdata_i
);
    import prefetch_pkg::*;

    // address fifo wiring
    logic                      addr_push;
    logic                      addr_pop;
    logic [ADDR_CNT_WIDTH-1:0] addr_usage;
    logic [ADDR_WIDTH-1:0]     addr_head;

    // instruction fifo wiring
    logic                       instr_push;
    logic [INSTR_CNT_WIDTH-1:0] instr_usage;
    logic                       instr_empty;
    fetch_entry_t               instr_entry;
    fetch_entry_t               instr_head;

    // core sees the head entry whenever the buffer holds something
    assign fetch_valid_o = ~instr_empty;
    assign fetch_addr_o  = instr_head.addr;
    assign fetch_instr_o = instr_head.instr;

    fetch_ctrl i_fetch_ctrl (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .branch_i           (branch_i),
        .branch_addr_i      (branch_addr_i),
        .instr_req_o        (instr_req_o),
        .instr_addr_o       (instr_addr_o),
        .instr_gnt_i        (instr_gnt_i),
        .instr_rvalid_i     (instr_rvalid_i),
        .instr_rdata_i      (instr_rdata_i),
        .addr_fifo_usage_i  (addr_usage),
        .instr_fifo_usage_i (instr_usage),
        .addr_fifo_data_i   (addr_head),
        .addr_fifo_push_o   (addr_push),
        .addr_fifo_pop_o    (addr_pop),
        .instr_fifo_push_o  (instr_push),
        .instr_fifo_data_o  (instr_entry)
    );

    // responses still arrive after a branch, so no flush here
    prefetch_fifo #(
        .DEPTH (MAX_OUTSTANDING),
        .dtype (logic [ADDR_WIDTH-1:0])
    ) i_addr_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (1'b0),
        .push_i  (addr_push),
        .pop_i   (addr_pop),
        .data_i  (instr_addr_o),
        .full_o  (),
        .empty_o (),
        .usage_o (addr_usage),
        .data_o  (addr_head)
    );

    // branch empties the buffer in the cycle after the strobe
    prefetch_fifo #(
        .DEPTH (FETCH_DEPTH),
        .dtype (fetch_entry_t)
    ) i_instr_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (branch_i),
        .push_i  (instr_push),
        .pop_i   (fetch_pop_i),
        .data_i  (instr_entry),
        .full_o  (),
        .empty_o (instr_empty),
        .usage_o (instr_usage),
        .data_o  (instr_head)
    );

endmodule

`default_nettype wire

/* tb_instr_mem.sv */
// instruction memory model for the prefetch testbench
// random grant, random in-order response latency, rdata = addr ^ key
`default_nettype none

module tb_instr_mem #(
    parameter logic [prefetch_pkg::ADDR_WIDTH-1:0] RDATA_KEY = '0,
    parameter int unsigned                         SEED      = 0
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 req_i,
    input  logic [prefetch_pkg::ADDR_WIDTH-1:0]  addr_i,
    output logic                                 gnt_o,
    output logic                                 rvalid_o,
    output logic [prefetch_pkg::INSTR_WIDTH-1:0] rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // granted addresses and the cycle each one may answer in
    logic [31:0] addr_q [$];
    int unsigned due_q [$];
    int unsigned cycle_q;
    logic        gnt_en_q;

    // grant is open in roughly three cycles out of four
    assign gnt_o = req_i & gnt_en_q;

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_en_q <= 1'b0;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
            cycle_q  <= 0;
            addr_q.delete();
            due_q.delete();
        end else begin
            // this process draws all the random grants and latencies
            if (cycle_q == 0) begin
                void'($urandom(SEED));
            end
            cycle_q  <= cycle_q + 1;
            gnt_en_q <= ($urandom % 4) != 32'd0;
            rvalid_o <= 1'b0;
            // latency of 1 to 3 cycles after the grant
            if (req_i && gnt_o) begin
                addr_q.push_back(addr_i);
                due_q.push_back(cycle_q + $urandom_range(3, 1));
            end
            // head blocks the rest, so responses stay in request order
            if (due_q.size() > 0 && due_q[0] <= cycle_q) begin
                rvalid_o <= 1'b1;
                rdata_o  <= addr_q.pop_front() ^ RDATA_KEY;
                void'(due_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

/* tb_prefetch_buffer.sv */
// testbench for the instruction prefetch buffer
// table driven steps of branches, idle gaps and pops, checked against a scoreboard
`default_nettype none

module tb_prefetch_buffer;
    timeunit 1ns;
    timeprecision 1ps;
    import prefetch_pkg::*;

    localparam logic [31:0] RDATA_KEY = 32'hA5C3_0F69;
    localparam int unsigned SEED      = 32'h1e856030;
    localparam int unsigned TIMEOUT   = 200;

    // idle cycles, pops, branch flag, branch target, expected first address
    typedef struct packed {
        int          idle;
        int          pops;
        bit          do_branch;
        logic [31:0] target;
        logic [31:0] first;
    } step_t;

    localparam int NUM_STEPS = 9;
    localparam step_t STEPS [NUM_STEPS] = '{
        '{0,  6, 1'b0, 32'h0000_0000, BOOT_ADDR},
        '{0,  5, 1'b1, 32'h0000_1000, 32'h0000_1000},
        '{40, 8, 1'b0, 32'h0000_0000, 32'h0000_1014},
        '{3,  4, 1'b1, 32'h0000_2000, 32'h0000_2000},
        '{0,  1, 1'b1, 32'h0000_3000, 32'h0000_3000},
        '{20, 6, 1'b1, 32'h0000_0040, 32'h0000_0040},
        '{2,  0, 1'b1, 32'h0000_5000, 32'h0000_0000},
        '{0,  4, 1'b1, 32'h0000_6000, 32'h0000_6000},
        '{30, 5, 1'b0, 32'h0000_0000, 32'h0000_6010}
    };

    logic        clk_i = 1'b0;
    logic        rst_ni = 1'b0;
    logic        branch_i = 1'b0;
    logic [31:0] branch_addr_i = '0;
    logic        fetch_pop_i = 1'b0;
    logic        fetch_valid_o;
    logic [31:0] fetch_addr_o;
    logic [31:0] fetch_instr_o;
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_rdata;

    // address of the next entry the core should see
    logic [31:0] exp_addr;
    // grants accepted since the last pop edge
    int unsigned req_since_pop;
    // a request still waiting for its grant and the address it showed
    logic        held_q = 1'b0;
    logic [31:0] held_addr_q = '0;

    always #4 clk_i = ~clk_i;

    prefetch_buffer i_prefetch_buffer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .branch_i       (branch_i),
        .branch_addr_i  (branch_addr_i),
        .fetch_pop_i    (fetch_pop_i),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_addr_o   (fetch_addr_o),
        .fetch_instr_o  (fetch_instr_o),
        .instr_req_o    (instr_req),
        .instr_addr_o   (instr_addr),
        .instr_gnt_i    (instr_gnt),
        .instr_rvalid_i (instr_rvalid),
        .instr_rdata_i  (instr_rdata)
    );

    tb_instr_mem #(
        .RDATA_KEY (RDATA_KEY),
        .SEED      (SEED)
    ) i_tb_instr_mem (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (instr_req),
        .addr_i   (instr_addr),
        .gnt_o    (instr_gnt),
        .rvalid_o (instr_rvalid),
        .rdata_o  (instr_rdata)
    );

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_since_pop <= 0;
        end else if (fetch_pop_i) begin
            req_since_pop <= 0;
        end else if (instr_req && instr_gnt) begin
            req_since_pop <= req_since_pop + 1;
        end
    end

    // bus address may not move while a request waits for its grant
    always @(posedge clk_i) begin
        if (rst_ni && held_q && instr_req) begin
            check("address of held request", instr_addr, held_addr_q);
        end
        held_q      <= rst_ni && instr_req && !instr_gnt;
        held_addr_q <= instr_addr;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR @ %0t: %s got %h expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // poll at the drive point, one cycle at a time
    task automatic wait_valid;
        int waited;
        waited = 0;
        while (!fetch_valid_o) begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout at %0t: no fetch entry became valid", $time);
                $display("*** FAILED ***");
                $fatal(1, "wait for valid timed out");
            end
        end
    endtask

    task automatic pop_entry;
        check("fetch address", fetch_addr_o, exp_addr);
        check("fetch instruction", fetch_instr_o, exp_addr ^ RDATA_KEY);
        fetch_pop_i = 1'b1;
        @(posedge clk_i);
        #1;
        fetch_pop_i = 1'b0;
        exp_addr = exp_addr + 32'd4;
    endtask

    task automatic take_branch(input logic [31:0] target);
        branch_i      = 1'b1;
        branch_addr_i = target;
        @(posedge clk_i);
        #1;
        branch_i = 1'b0;
        // buffer is flushed by the strobe edge
        check("valid after branch", 32'(fetch_valid_o), 32'd0);
        exp_addr = target;
    endtask

    task automatic run_step(input step_t st);
        if (st.do_branch) begin
            take_branch(st.target);
        end
        repeat (st.idle) begin
            @(posedge clk_i);
            #1;
            // stale requests after a branch fall outside this bound
            if (!st.do_branch) begin
                check("requests since pop within depth",
                      32'(req_since_pop <= FETCH_DEPTH), 32'd1);
            end
        end
        for (int i = 0; i < st.pops; i++) begin
            wait_valid();
            if (i == 0) begin
                check("first address of step", fetch_addr_o, st.first);
            end
            pop_entry();
        end
    endtask

    initial begin
        exp_addr = BOOT_ADDR;
        repeat (4) begin
            @(posedge clk_i);
            #1;
            check("valid during reset", 32'(fetch_valid_o), 32'd0);
            check("request during reset", 32'(instr_req), 32'd0);
        end
        rst_ni = 1'b1;
        for (int s = 0; s < NUM_STEPS; s++) begin
            run_step(STEPS[s]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
prefetch_pkg.sv
prefetch_fifo.sv
fetch_ctrl.sv
prefetch_buffer.sv
tb_instr_mem.sv
tb_prefetch_buffer.sv

/* Makefile */
TOP = tb_prefetch_buffer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f flist.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
